//--- include/shift_config.svh
`ifndef SHIFT_CONFIG_SVH
`define SHIFT_CONFIG_SVH

// operand and result width in bits, the shift amount width follows from it
`define SHIFT_DATA_WIDTH 32

// entries per request queue
// each sender starts out with this many credits
`define SHIFT_QUEUE_DEPTH 4

`define SHIFT_NUM_PORTS 2 // issue ports sharing the one shift pipeline

`endif

//--- source/shift_pkg.sv
`default_nettype none

`include "shift_config.svh"

package shift_pkg;

    typedef logic [`SHIFT_DATA_WIDTH-1:0] data_t;
    typedef logic [$clog2(`SHIFT_DATA_WIDTH)-1:0] shamt_t;
    typedef logic [$clog2(`SHIFT_NUM_PORTS)-1:0] port_id_t;

    // operation encoding, left shifts always fill with zero
    typedef logic [1:0] shift_op_t;
    localparam shift_op_t OP_SLL = 2'd0;
    localparam shift_op_t OP_SRL = 2'd1;
    localparam shift_op_t OP_SRA = 2'd2;

    typedef struct packed {
        shift_op_t op;
        shamt_t    shamt;
        data_t     data;
    } shift_req_t;

    typedef struct packed {
        port_id_t   port; // requesting port, carried through to the result
        shift_req_t req;
    } issue_t;

    typedef struct packed {
        port_id_t port;
        data_t    data;
    } shift_result_t;

endpackage

`default_nettype wire

//--- source/request_queue.sv
`default_nettype none

module request_queue import shift_pkg::*; #(
    parameter int DEPTH = 4
) (
    input  wire logic       clk,
    input  wire logic       arst_n,
    input  wire logic       push,
    input  wire shift_req_t push_req,
    input  wire logic       pop,
    output logic            not_empty,
    output shift_req_t      head,
    output logic            credit
);

    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    shift_req_t mem [DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;

    // entries are written blindly, the sender's credits keep it from overrunning
    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr] <= push_req;
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
            credit <= 1'b0;
        end else begin
            if (push) begin
                if (wr_ptr == PTR_W'(DEPTH - 1)) begin
                    wr_ptr <= '0;
                end else begin
                    wr_ptr <= wr_ptr + 1'b1;
                end
            end
            if (pop) begin
                if (rd_ptr == PTR_W'(DEPTH - 1)) begin
                    rd_ptr <= '0;
                end else begin
                    rd_ptr <= rd_ptr + 1'b1;
                end
            end
            count  <= count + CNT_W'(push) - CNT_W'(pop);
            credit <= pop; // one credit back per released entry
        end
    end

    assign not_empty = (count != '0);
    assign head      = mem[rd_ptr]; // head is only meaningful while not_empty

endmodule

`default_nettype wire

//--- source/issue_arbiter.sv
`default_nettype none

`include "shift_config.svh"

module issue_arbiter import shift_pkg::*; (
    input  wire logic                        clk,
    input  wire logic                        arst_n,
    input  wire logic [`SHIFT_NUM_PORTS-1:0] not_empty,
    input  wire shift_req_t                  head0,
    input  wire shift_req_t                  head1,
    output logic [`SHIFT_NUM_PORTS-1:0]      pop,
    output logic                             issue_valid,
    output issue_t                           issue
);

    port_id_t prio;   // port that wins when both queues hold work
    port_id_t winner;

    // the favoured port goes first, the other one only if it has nothing
    always_comb begin
        winner = prio;
        if (!not_empty[prio]) begin
            winner = ~prio;
        end
    end

    assign issue_valid = |not_empty;

    always_comb begin
        pop = '0;
        if (issue_valid) begin
            pop[winner] = 1'b1;
        end
    end

    assign issue.port = winner;
    assign issue.req  = winner ? head1 : head0;

    // after a grant the other port gets priority, so back to back
    // contention alternates starting with port 0
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            prio <= '0;
        end else if (issue_valid) begin
            prio <= ~winner;
        end
    end

endmodule

`default_nettype wire

//--- source/barrel_shifter.sv
`default_nettype none

`include "shift_config.svh"

module barrel_shifter import shift_pkg::*; #(
    parameter int DATA_WIDTH = `SHIFT_DATA_WIDTH
) (
    input  wire data_t  d_in,
    input  wire shamt_t shamt,
    input  wire logic   arith,
    input  wire logic   right,
    output data_t       d_out
);

    localparam int STAGES = $clog2(DATA_WIDTH);

    logic [DATA_WIDTH-1:0] d_rev;
    logic [DATA_WIDTH-1:0] stage [STAGES+1];
    logic [DATA_WIDTH-1:0] out_rev;
    logic                  fill;

    // sign fill only on arithmetic right shifts, the decoder never sets arith for left
    assign fill = arith & d_in[DATA_WIDTH-1];

    // the array only shifts right, a left shift runs on the mirrored word
    for (genvar i = 0; i < DATA_WIDTH; i++) begin : g_rev_in
        assign d_rev[i] = d_in[DATA_WIDTH-1-i];
    end

    assign stage[0] = right ? d_in : d_rev;

    // stage k moves the word right by 2**k when shamt bit k is set
    for (genvar k = 0; k < STAGES; k++) begin : g_stage
        localparam int STEP = 1 << k;
        assign stage[k+1] = shamt[k]
                          ? {{STEP{fill}}, stage[k][DATA_WIDTH-1:STEP]}
                          : stage[k];
    end

    for (genvar i = 0; i < DATA_WIDTH; i++) begin : g_rev_out
        assign out_rev[i] = stage[STAGES][DATA_WIDTH-1-i];
    end

    assign d_out = right ? stage[STAGES] : out_rev; // mirror back for left shifts

endmodule

`default_nettype wire

//--- source/shift_pipeline.sv
`default_nettype none

`include "shift_config.svh"

module shift_pipeline import shift_pkg::*; (
    input  wire logic   clk,
    input  wire logic   arst_n,
    input  wire logic   issue_valid,
    input  wire issue_t issue,
    output logic        res_valid,
    output shift_result_t res
);

    logic   iss_valid;
    issue_t iss;
    logic   arith;
    logic   right;
    data_t  shifted;

    // issue register, first edge
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            iss_valid <= 1'b0;
        end else begin
            iss_valid <= issue_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (issue_valid) begin
            iss <= issue;
        end
    end

    assign arith = (iss.req.op == OP_SRA);
    assign right = (iss.req.op != OP_SLL); // both SRL and SRA go right

    barrel_shifter #(
        .DATA_WIDTH (`SHIFT_DATA_WIDTH)
    ) barrel_shifter_i (
        .d_in  (iss.req.data),
        .shamt (iss.req.shamt),
        .arith (arith),
        .right (right),
        .d_out (shifted)
    );

    // result register on the second edge keeps the port tag with its word
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            res_valid <= 1'b0;
        end else begin
            res_valid <= iss_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (iss_valid) begin
            res.port <= iss.port;
            res.data <= shifted;
        end
    end

endmodule

`default_nettype wire

//--- source/shift_cluster.sv
`default_nettype none

`include "shift_config.svh"

module shift_cluster import shift_pkg::*; (
    input  wire logic                        clk,
    input  wire logic                        arst_n,
    input  wire logic [`SHIFT_NUM_PORTS-1:0] req_valid,
    input  wire shift_req_t                  req0,
    input  wire shift_req_t                  req1,
    output logic [`SHIFT_NUM_PORTS-1:0]      credit,
    output logic                             res_valid,
    output shift_result_t                    res
);

    logic [`SHIFT_NUM_PORTS-1:0] not_empty;
    logic [`SHIFT_NUM_PORTS-1:0] pop;
    shift_req_t                  head0;
    shift_req_t                  head1;
    logic                        issue_valid;
    issue_t                      issue;

    request_queue #(
        .DEPTH (`SHIFT_QUEUE_DEPTH)
    ) request_queue_0_i (
        .clk       (clk),
        .arst_n    (arst_n),
        .push      (req_valid[0]),
        .push_req  (req0),
        .pop       (pop[0]),
        .not_empty (not_empty[0]),
        .head      (head0),
        .credit    (credit[0])
    );

    request_queue #(
        .DEPTH (`SHIFT_QUEUE_DEPTH)
    ) request_queue_1_i (
        .clk       (clk),
        .arst_n    (arst_n),
        .push      (req_valid[1]),
        .push_req  (req1),
        .pop       (pop[1]),
        .not_empty (not_empty[1]),
        .head      (head1),
        .credit    (credit[1])
    );

    issue_arbiter issue_arbiter_i (
        .clk         (clk),
        .arst_n      (arst_n),
        .not_empty   (not_empty),
        .head0       (head0),
        .head1       (head1),
        .pop         (pop),
        .issue_valid (issue_valid),
        .issue       (issue)
    );

    shift_pipeline shift_pipeline_i (
        .clk         (clk),
        .arst_n      (arst_n),
        .issue_valid (issue_valid),
        .issue       (issue),
        .res_valid   (res_valid),
        .res         (res)
    );

endmodule

`default_nettype wire

//--- tests/shift_cluster_assert.sv
`default_nettype none

module shift_cluster_assert #(
    parameter int DEPTH = 4
) (
    input wire logic                         clk,
    input wire logic                         arst_n,
    input wire logic                         push,
    input wire logic                         pop,
    input wire logic                         not_empty,
    input wire logic [$clog2(DEPTH+1)-1:0]   count,
    input wire logic                         credit
);

    localparam int CNT_W = $clog2(DEPTH + 1);
    localparam logic [CNT_W-1:0] FULL = CNT_W'(DEPTH);

    logic full_fail  = 1'b0;
    logic empty_fail = 1'b0;
    logic reset_fail = 1'b0;
    logic failed;

    assign failed = full_fail | empty_fail | reset_fail; // read by the testbench at the end

    no_push_when_full: assert property (
        @(posedge clk) disable iff (!arst_n) push |-> (count != FULL)
    ) else begin
        $error("push into a full request queue");
        full_fail = 1'b1;
    end

    no_pop_when_empty: assert property (
        @(posedge clk) disable iff (!arst_n) pop |-> not_empty
    ) else begin
        $error("pop from an empty request queue");
        empty_fail = 1'b1;
    end

    // a credit pulse right at reset release would hand out a slot that never existed
    no_credit_at_reset_release: assert property (
        @(posedge clk) $rose(arst_n) |-> !credit
    ) else begin
        $error("credit high when reset was released");
        reset_fail = 1'b1;
    end

endmodule

bind request_queue shift_cluster_assert #(
    .DEPTH (DEPTH)
) shift_cluster_assert_i (
    .clk       (clk),
    .arst_n    (arst_n),
    .push      (push),
    .pop       (pop),
    .not_empty (not_empty),
    .count     (count),
    .credit    (credit)
);

`default_nettype wire

//--- tests/shift_cluster_tb.sv
`default_nettype none

`include "shift_config.svh"

module shift_cluster_tb import shift_pkg::*; ();

    localparam int NUM_PORTS       = `SHIFT_NUM_PORTS;
    localparam int DEPTH           = `SHIFT_QUEUE_DEPTH;
    localparam int TRACE_LINES     = 22;
    localparam int RANDOM_PER_PORT = 40;
    localparam int TOTAL_REQS      = TRACE_LINES + NUM_PORTS * RANDOM_PER_PORT;
    localparam int CYCLE_LIMIT     = 4 * TOTAL_REQS + 100;

    typedef struct packed {
        shift_req_t req;
        data_t      expected;
    } stim_t;

    logic                 clk;
    logic                 arst_n;
    logic [NUM_PORTS-1:0] req_valid;
    shift_req_t           req0;
    shift_req_t           req1;
    logic [NUM_PORTS-1:0] credit;
    logic                 res_valid;
    shift_result_t        res;

    logic [31:0] trace_mem [TRACE_LINES*5]; // five words per trace line
    stim_t       stim_q [NUM_PORTS][$];
    data_t       exp_q [NUM_PORTS][$];
    int          credits [NUM_PORTS];
    int          cycles = 0;
    int          checks = 0;
    int          errors = 0;
    int          fair_errors = 0;
    int          alternations = 0;
    port_id_t    last_port = '0;
    bit          have_last = 1'b0;
    logic [31:0] lcg_state;

    shift_cluster shift_cluster_i (
        .clk       (clk),
        .arst_n    (arst_n),
        .req_valid (req_valid),
        .req0      (req0),
        .req1      (req1),
        .credit    (credit),
        .res_valid (res_valid),
        .res       (res)
    );

    always #10 clk = ~clk;

    // ends the run if results stop coming
    always @(posedge clk) begin
        if (arst_n) begin
            cycles <= cycles + 1;
            if (cycles >= CYCLE_LIMIT) begin
                $display("timeout: the run did not finish within %0d cycles", CYCLE_LIMIT);
                $display("Done: errors found");
                $finish;
            end
        end
    end

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1103515245 + 32'd12345;
    endfunction

    function automatic data_t shift_model(input shift_op_t op, input shamt_t shamt,
                                          input data_t d);
        case (op)
            OP_SLL:  return d << shamt;
            OP_SRL:  return d >> shamt;
            default: return data_t'($signed(d) >>> shamt); // sign bit fills from the top
        endcase
    endfunction

    // each clock checks a result, collects credits and then drives the next requests
    task automatic run_cycle();
        logic [NUM_PORTS-1:0] next_valid;
        stim_t                s;
        data_t                expected;
        port_id_t             other;
        @(posedge clk);
        if (res_valid) begin
            checks++;
            assert (exp_q[res.port].size() > 0) else begin
                $display("a result for port %0d arrived with no request outstanding", res.port);
                errors++;
            end
            if (exp_q[res.port].size() > 0) begin
                expected = exp_q[res.port].pop_front();
                assert (res.data == expected) else begin
                    $display("[ERROR] %0t: port %0d result %h, expected %h",
                             $time, res.port, res.data, expected);
                    errors++;
                end
            end
            other = ~res.port;
            // a repeat grant is only legal if the other queue was empty at issue time
            if (have_last && last_port == res.port) begin
                assert (exp_q[other].size() < DEPTH) else begin
                    $display("port %0d was granted twice while port %0d had work queued",
                             res.port, other);
                    errors++;
                    fair_errors++;
                end
            end else if (have_last) begin
                alternations++;
            end
            last_port = res.port;
            have_last = 1'b1;
        end
        next_valid = '0;
        for (int p = 0; p < NUM_PORTS; p++) begin
            if (credit[p]) begin
                credits[p]++;
            end
            assert (credits[p] <= DEPTH) else begin
                $display("port %0d got more credits back than it spent", p);
                errors++;
            end
            if (stim_q[p].size() > 0 && credits[p] > 0) begin
                s = stim_q[p].pop_front();
                exp_q[p].push_back(s.expected);
                credits[p]--;
                next_valid[p] = 1'b1;
                if (p == 0) begin
                    req0 <= s.req;
                end else begin
                    req1 <= s.req;
                end
            end
        end
        req_valid <= next_valid;
    endtask

    task automatic drain_ports();
        while (stim_q[0].size() > 0 || stim_q[1].size() > 0 ||
               exp_q[0].size() > 0 || exp_q[1].size() > 0) begin
            run_cycle();
        end
        repeat (3) run_cycle(); // catches stray results and late credit pulses
    endtask

    initial begin
        int    err_before;
        int    chk_before;
        int    alt_before;
        stim_t s;
        clk = 1'b0;
        arst_n <= 1'b0;
        req_valid <= '0;
        req0 <= '0;
        req1 <= '0;
        $readmemh("tests/shift_trace.txt", trace_mem);
        for (int p = 0; p < NUM_PORTS; p++) begin
            credits[p] = DEPTH;
        end
        repeat (8) @(posedge clk);
        arst_n <= 1'b1;

        err_before = errors;
        chk_before = checks;
        for (int line = 0; line < TRACE_LINES; line++) begin
            s.req.op    = shift_op_t'(trace_mem[line*5+1]);
            s.req.shamt = shamt_t'(trace_mem[line*5+2]);
            s.req.data  = trace_mem[line*5+3];
            s.expected  = trace_mem[line*5+4];
            stim_q[trace_mem[line*5][0]].push_back(s);
        end
        drain_ports();
        $display("test trace_shifts: %0d results, %0d errors",
                 checks - chk_before, errors - err_before);

        err_before = errors;
        chk_before = checks;
        alt_before = alternations;
        lcg_state = 32'd21194;
        for (int i = 0; i < RANDOM_PER_PORT; i++) begin
            for (int p = 0; p < NUM_PORTS; p++) begin
                lcg_state   = lcg_next(lcg_state);
                s.req.op    = shift_op_t'(lcg_state % 32'd3);
                s.req.shamt = lcg_state[28:24];
                lcg_state   = lcg_next(lcg_state);
                s.req.data  = lcg_state;
                s.expected  = shift_model(s.req.op, s.req.shamt, s.req.data);
                stim_q[p].push_back(s);
            end
        end
        drain_ports();
        $display("test random_mixed: %0d results, %0d errors",
                 checks - chk_before, errors - err_before);

        err_before = errors;
        for (int p = 0; p < NUM_PORTS; p++) begin
            assert (credits[p] == DEPTH) else begin
                $display("[ERROR] %0t: port %0d holds %0d credits after drain, expected %0d",
                         $time, p, credits[p], DEPTH);
                errors++;
            end
        end
        assert (!shift_cluster_i.request_queue_0_i.shift_cluster_assert_i.failed &&
                !shift_cluster_i.request_queue_1_i.shift_cluster_assert_i.failed) else begin
            $display("a request queue protocol assertion failed during the run");
            errors++;
        end
        $display("test credit_return: %0d errors", errors - err_before);

        // saturated traffic on both ports should alternate almost every time
        assert (alternations - alt_before >= RANDOM_PER_PORT) else begin
            $display("results alternated only %0d times under full load",
                     alternations - alt_before);
            errors++;
            fair_errors++;
        end
        $display("test fairness: %0d alternations, %0d errors",
                 alternations - alt_before, fair_errors);

        $display("%0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- sources.f
+incdir+include
source/shift_pkg.sv
source/request_queue.sv
source/issue_arbiter.sv
source/barrel_shifter.sv
source/shift_pipeline.sv
source/shift_cluster.sv
tests/shift_cluster_assert.sv
tests/shift_cluster_tb.sv

//--- Makefile
# Verilator build and run for the shift cluster testbench

VERILATOR ?= verilator
TOP       ?= shift_cluster_tb
FILELIST  ?= sources.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0
PASS_MSG  ?= Done: no errors

SIM := $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# the run passes only if the pass message shows up on a line of its own
run: compile
	$(SIM) | tee /dev/stderr | grep -Fqx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

//--- tests/shift_trace.txt
// columns: port op shamt data expected, all hex
// op 0 is logical left, 1 logical right, 2 arithmetic right
0 1 00 DEADBEEF DEADBEEF
0 1 04 80000000 08000000
1 1 1F FFFFFFFF 00000001
1 1 08 12345678 00123456
0 1 10 ABCD1234 0000ABCD
0 2 04 80000000 F8000000
1 2 1F 80000000 FFFFFFFF
1 2 08 7FFFFFFF 007FFFFF
0 2 00 C0000001 C0000001
1 2 10 ABCD1234 FFFFABCD
0 2 03 40000000 08000000
1 2 01 FFFFFFFE FFFFFFFF
0 0 01 00000001 00000002
1 0 1F 00000001 80000000
0 0 1F FFFFFFFF 80000000
1 0 04 12345678 23456780
0 0 10 ABCD1234 12340000
1 0 00 CAFEF00D CAFEF00D
0 0 08 FFFFFFFF FFFFFF00
1 1 04 F0F0F0F0 0F0F0F0F
0 2 04 F0F0F0F0 FF0F0F0F
1 0 04 F0F0F0F0 0F0F0F00
